// File: rtl/l2_geom_pkg.sv
package l2_geom_pkg;

    //////////////////////////////////////////////////
    // base geometry
    //////////////////////////////////////////////////
    localparam int WORD_BITS   = 32;     // data and address width
    localparam int CACHE_BITS  = 4096;   // total data capacity
    localparam int BLOCK_WORDS = 4;      // words per frame
    localparam int WAYS        = 4;      // associativity

    // derived sizes
    localparam int N_SETS = CACHE_BITS / (WORD_BITS * BLOCK_WORDS * WAYS);

    //////////////////////////////////////////////////
    // address fields, from lsb up
    //////////////////////////////////////////////////
    localparam int BYTE_OFS_BITS = 2;                      // byte within word
    localparam int WORD_SEL_BITS = $clog2(BLOCK_WORDS);    // word within block
    localparam int SET_BITS      = $clog2(N_SETS);
    localparam int WAY_BITS      = $clog2(WAYS);
    localparam int TAG_BITS      = WORD_BITS - SET_BITS - WORD_SEL_BITS - BYTE_OFS_BITS;

    // everything from here up bypasses the cache
    localparam logic [WORD_BITS-1:0] NONCACHE_BASE = 32'h8000_0000;

endpackage

// File: rtl/l2_ctrl_pkg.sv
package l2_ctrl_pkg;

    //////////////////////////////////////////////////
    // miss controller states
    //////////////////////////////////////////////////
    typedef enum logic [1:0] {
        IDLE      = 2'd0,    // serving hits and pass-through
        WRITEBACK = 2'd1,    // dirty victim out to memory
        REFILL    = 2'd2     // new block in from memory
    } l2_state_t;

    // memory bus addressing
    localparam int unsigned WORD_STEP = 4;    // byte increment per burst word

endpackage

// File: rtl/l2_frame_store.sv
`timescale 1ns/1ps

module l2_frame_store import l2_geom_pkg::*; (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic [WORD_BITS-1:0]     lookup_addr,
    input  logic [WAY_BITS-1:0]      fill_way,
    input  logic [WORD_SEL_BITS-1:0] fill_word,
    input  logic [WORD_BITS-1:0]     fill_data,
    input  logic                     fill_we,
    input  logic                     install,
    input  logic                     wb_done,
    input  logic                     hit_we,
    input  logic [WORD_BITS-1:0]     hit_wdata,
    output logic                     hit,
    output logic [WAY_BITS-1:0]      hit_way,
    output logic [WORD_BITS-1:0]     hit_rdata,
    output logic                     victim_dirty,
    output logic [TAG_BITS-1:0]      victim_tag,
    output logic [WORD_BITS-1:0]     victim_word
);

    logic                 valid [N_SETS][WAYS];
    logic                 dirty [N_SETS][WAYS];
    logic [TAG_BITS-1:0]  tag   [N_SETS][WAYS];
    logic [WORD_BITS-1:0] data  [N_SETS][WAYS][BLOCK_WORDS];

    logic [SET_BITS-1:0]      set_idx;
    logic [WORD_SEL_BITS-1:0] word_idx;
    logic [TAG_BITS-1:0]      req_tag;

    assign word_idx = lookup_addr[BYTE_OFS_BITS +: WORD_SEL_BITS];
    assign set_idx  = lookup_addr[BYTE_OFS_BITS + WORD_SEL_BITS +: SET_BITS];
    assign req_tag  = lookup_addr[WORD_BITS-1 -: TAG_BITS];

    //////////////////////////////////////////////////
    // lookup, all ways of the set in parallel
    //////////////////////////////////////////////////
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid[set_idx][w] && (tag[set_idx][w] == req_tag)) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign hit_rdata = data[set_idx][hit_way][word_idx];

    // frame picked by the controller for eviction and refill
    assign victim_dirty = dirty[set_idx][fill_way];
    assign victim_tag   = tag[set_idx][fill_way];
    assign victim_word  = data[set_idx][fill_way][fill_word];

    //////////////////////////////////////////////////
    // status bits
    //////////////////////////////////////////////////
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    valid[s][w] <= 1'b0;
                    dirty[s][w] <= 1'b0;
                end
            end
        end else begin
            if (install) begin
                valid[set_idx][fill_way] <= 1'b1;
                dirty[set_idx][fill_way] <= 1'b0;    // fresh block matches memory
            end else if (wb_done) begin
                dirty[set_idx][fill_way] <= 1'b0;
            end
            if (hit_we) begin
                dirty[set_idx][hit_way] <= 1'b1;
            end
        end
    end

    // tags and block data
    always_ff @(posedge CLK) begin
        if (install) begin
            tag[set_idx][fill_way] <= req_tag;
        end
        if (fill_we) begin
            data[set_idx][fill_way][fill_word] <= fill_data;
        end
        if (hit_we) begin
            data[set_idx][hit_way][word_idx] <= hit_wdata;
        end
    end

    // refills happen outside IDLE, write hits only inside it
    assert property (@(posedge CLK) disable iff (!nRST) !(install && hit_we))
        else $error("install and write hit in the same cycle");

endmodule

// File: rtl/l2_lru.sv
`timescale 1ns/1ps

module l2_lru import l2_geom_pkg::*; (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic [WORD_BITS-1:0] lookup_addr,
    input  logic                 touch,
    input  logic [WAY_BITS-1:0]  touch_way,
    output logic [WAY_BITS-1:0]  victim_way
);

    logic [WAY_BITS-1:0] order [N_SETS][WAYS];    // entry 0 is the oldest way
    logic [WAY_BITS-1:0] next_order [WAYS];
    logic [SET_BITS-1:0] set_idx;
    logic [N_SETS-1:0]   set_distinct;

    assign set_idx    = lookup_addr[BYTE_OFS_BITS + WORD_SEL_BITS +: SET_BITS];
    assign victim_way = order[set_idx][0];

    // touched way goes to the newest slot, the ones after it shift down
    always_comb begin : touch_shift
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < WAYS - 1; i++) begin
            if (order[set_idx][i] == touch_way) begin
                seen = 1'b1;
            end
            next_order[i] = seen ? order[set_idx][i+1] : order[set_idx][i];
        end
        next_order[WAYS-1] = touch_way;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < N_SETS; s++) begin
                for (int i = 0; i < WAYS; i++) begin
                    order[s][i] <= WAY_BITS'(i);    // way 0 oldest
                end
            end
        end else if (touch) begin
            for (int i = 0; i < WAYS; i++) begin
                order[set_idx][i] <= next_order[i];
            end
        end
    end

    // every set must keep a permutation of the ways
    always_comb begin : perm_check
        logic [WAYS-1:0] present;
        for (int s = 0; s < N_SETS; s++) begin
            present = '0;
            for (int i = 0; i < WAYS; i++) begin
                present[order[s][i]] = 1'b1;
            end
            set_distinct[s] = &present;
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST) &set_distinct)
        else $error("lru order of a set holds a duplicate way");

endmodule

// File: rtl/l2_controller.sv
`timescale 1ns/1ps

module l2_controller import l2_geom_pkg::*, l2_ctrl_pkg::*; (
    input  logic                     CLK,
    input  logic                     nRST,
    input  logic [WORD_BITS-1:0]     proc_addr,
    input  logic                     proc_ren,
    input  logic                     proc_wen,
    input  logic [WORD_BITS-1:0]     proc_wdata,
    output logic [WORD_BITS-1:0]     proc_rdata,
    output logic                     proc_busy,
    output logic [WORD_BITS-1:0]     mem_addr,
    output logic                     mem_ren,
    output logic                     mem_wen,
    output logic [WORD_BITS-1:0]     mem_wdata,
    input  logic [WORD_BITS-1:0]     mem_rdata,
    input  logic                     mem_busy,
    input  logic                     hit,
    input  logic [WAY_BITS-1:0]      hit_way,
    input  logic [WORD_BITS-1:0]     hit_rdata,
    input  logic [WAY_BITS-1:0]      victim_way,
    input  logic                     victim_dirty,
    input  logic [TAG_BITS-1:0]      victim_tag,
    input  logic [WORD_BITS-1:0]     victim_word,
    output logic                     fill_we,
    output logic                     install,
    output logic                     wb_done,
    output logic                     hit_we,
    output logic [WAY_BITS-1:0]      fill_way,
    output logic [WORD_SEL_BITS-1:0] fill_word,
    output logic [WORD_BITS-1:0]     fill_data,
    output logic [WORD_BITS-1:0]     hit_wdata,
    output logic                     touch,
    output logic [WAY_BITS-1:0]      touch_way
);

    l2_state_t state, next_state;

    logic [WORD_SEL_BITS-1:0] word_cnt;
    logic [WORD_BITS-1:0]     burst_addr;
    logic [WAY_BITS-1:0]      vic_way;     // victim held for the whole miss
    logic [SET_BITS-1:0]      set_idx;
    logic [WORD_BITS-1:0]     refill_base;
    logic [WORD_BITS-1:0]     wb_base;
    logic                     req;
    logic                     uncached;
    logic                     miss;
    logic                     word_done;
    logic                     last_word;

    assign req       = proc_ren | proc_wen;
    assign uncached  = proc_addr >= NONCACHE_BASE;
    assign set_idx   = proc_addr[WORD_SEL_BITS + BYTE_OFS_BITS +: SET_BITS];
    assign miss      = (state == IDLE) && req && !uncached && !hit;
    assign word_done = (state != IDLE) && !mem_busy;    // one burst word accepted
    assign last_word = word_cnt == WORD_SEL_BITS'(BLOCK_WORDS - 1);

    // block-aligned burst start addresses
    assign refill_base = {proc_addr[WORD_BITS-1:WORD_SEL_BITS + BYTE_OFS_BITS],
                          {(WORD_SEL_BITS + BYTE_OFS_BITS){1'b0}}};
    assign wb_base     = {victim_tag, set_idx, {(WORD_SEL_BITS + BYTE_OFS_BITS){1'b0}}};

    //////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (miss) begin
                    next_state = victim_dirty ? WRITEBACK : REFILL;
                end
            end
            WRITEBACK: begin
                if (word_done && last_word) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                if (word_done && last_word) begin
                    next_state = IDLE;    // access hits on the next cycle
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            word_cnt <= '0;
        end else begin
            state <= next_state;
            if (word_done) begin
                word_cnt <= word_cnt + 1'b1;    // wraps to 0 after the last word
            end
        end
    end

    // burst address and victim way
    always_ff @(posedge CLK) begin
        if (miss) begin
            vic_way    <= victim_way;
            burst_addr <= victim_dirty ? wb_base : refill_base;
        end else if (word_done) begin
            if ((state == WRITEBACK) && last_word) begin
                burst_addr <= refill_base;
            end else begin
                burst_addr <= burst_addr + WORD_BITS'(WORD_STEP);
            end
        end
    end

    //////////////////////////////////////////////////
    // bus steering and frame store strobes
    //////////////////////////////////////////////////
    always_comb begin
        proc_busy = 1'b1;
        mem_ren   = 1'b0;
        mem_wen   = 1'b0;
        mem_addr  = burst_addr;
        mem_wdata = victim_word;
        hit_we    = 1'b0;
        fill_we   = 1'b0;
        install   = 1'b0;
        wb_done   = 1'b0;
        touch     = 1'b0;
        case (state)
            IDLE: begin
                if (uncached) begin
                    mem_addr  = proc_addr;
                    mem_wdata = proc_wdata;
                    mem_ren   = proc_ren;
                    mem_wen   = proc_wen & ~proc_ren;    // read wins if both
                    if (req) begin
                        proc_busy = mem_busy;
                    end
                end else if (req) begin
                    touch = 1'b1;    // hit way, or the victim as a miss starts
                    if (hit) begin
                        proc_busy = 1'b0;
                        hit_we    = proc_wen;
                    end
                end
            end
            WRITEBACK: begin
                mem_wen = 1'b1;
                wb_done = !mem_busy && last_word;
            end
            REFILL: begin
                mem_ren = 1'b1;
                fill_we = !mem_busy;
                install = !mem_busy && last_word;
            end
            default: proc_busy = 1'b1;
        endcase
    end

    assign proc_rdata = uncached ? mem_rdata : hit_rdata;
    assign fill_way   = (state == IDLE) ? victim_way : vic_way;
    assign fill_word  = word_cnt;
    assign fill_data  = mem_rdata;
    assign hit_wdata  = proc_wdata;
    assign touch_way  = hit ? hit_way : victim_way;

    assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen))
        else $error("mem_ren and mem_wen high together");

    assert property (@(posedge CLK) disable iff (!nRST)
                     state inside {IDLE, WRITEBACK, REFILL})
        else $error("controller state out of range");

endmodule

// File: rtl/l2_cache.sv
`timescale 1ns/1ps

module l2_cache import l2_geom_pkg::*; (
    input  logic                 CLK,
    input  logic                 nRST,
    // processor side
    input  logic [WORD_BITS-1:0] proc_addr,
    input  logic                 proc_ren,
    input  logic                 proc_wen,
    input  logic [WORD_BITS-1:0] proc_wdata,
    output logic [WORD_BITS-1:0] proc_rdata,
    output logic                 proc_busy,
    // memory side
    output logic [WORD_BITS-1:0] mem_addr,
    output logic                 mem_ren,
    output logic                 mem_wen,
    output logic [WORD_BITS-1:0] mem_wdata,
    input  logic [WORD_BITS-1:0] mem_rdata,
    input  logic                 mem_busy
);

    // lookup results
    logic                     hit;
    logic [WAY_BITS-1:0]      hit_way;
    logic [WORD_BITS-1:0]     hit_rdata;
    logic                     victim_dirty;
    logic [TAG_BITS-1:0]      victim_tag;
    logic [WORD_BITS-1:0]     victim_word;
    logic [WAY_BITS-1:0]      victim_way;

    // frame store writes
    logic                     fill_we;
    logic                     install;
    logic                     wb_done;
    logic                     hit_we;
    logic [WAY_BITS-1:0]      fill_way;
    logic [WORD_SEL_BITS-1:0] fill_word;
    logic [WORD_BITS-1:0]     fill_data;
    logic [WORD_BITS-1:0]     hit_wdata;

    // replacement update
    logic                     touch;
    logic [WAY_BITS-1:0]      touch_way;

    l2_frame_store frame_store_inst (
        .CLK          (CLK),
        .nRST         (nRST),
        .lookup_addr  (proc_addr),
        .fill_way     (fill_way),
        .fill_word    (fill_word),
        .fill_data    (fill_data),
        .fill_we      (fill_we),
        .install      (install),
        .wb_done      (wb_done),
        .hit_we       (hit_we),
        .hit_wdata    (hit_wdata),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_rdata    (hit_rdata),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_word  (victim_word)
    );

    l2_lru lru_inst (
        .CLK         (CLK),
        .nRST        (nRST),
        .lookup_addr (proc_addr),
        .touch       (touch),
        .touch_way   (touch_way),
        .victim_way  (victim_way)
    );

    l2_controller controller_inst (
        .CLK          (CLK),
        .nRST         (nRST),
        .proc_addr    (proc_addr),
        .proc_ren     (proc_ren),
        .proc_wen     (proc_wen),
        .proc_wdata   (proc_wdata),
        .proc_rdata   (proc_rdata),
        .proc_busy    (proc_busy),
        .mem_addr     (mem_addr),
        .mem_ren      (mem_ren),
        .mem_wen      (mem_wen),
        .mem_wdata    (mem_wdata),
        .mem_rdata    (mem_rdata),
        .mem_busy     (mem_busy),
        .hit          (hit),
        .hit_way      (hit_way),
        .hit_rdata    (hit_rdata),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_word  (victim_word),
        .fill_we      (fill_we),
        .install      (install),
        .wb_done      (wb_done),
        .hit_we       (hit_we),
        .fill_way     (fill_way),
        .fill_word    (fill_word),
        .fill_data    (fill_data),
        .hit_wdata    (hit_wdata),
        .touch        (touch),
        .touch_way    (touch_way)
    );

endmodule

// File: bench/l2_mem_model.sv
`timescale 1ns/1ps

module l2_mem_model import l2_geom_pkg::*; (
    input  logic                 CLK,
    input  logic [WORD_BITS-1:0] mem_addr,
    input  logic                 mem_ren,
    input  logic                 mem_wen,
    input  logic [WORD_BITS-1:0] mem_wdata,
    output logic [WORD_BITS-1:0] mem_rdata,
    output logic                 mem_busy
);

    logic [WORD_BITS-1:0] store [logic [WORD_BITS-1:0]];    // only words written so far
    logic [31:0]          lfsr;
    int unsigned          wr_count;                         // bumps rdata after a write
    logic                 stall_a;
    logic                 stall_b;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [WORD_BITS-1:0] read_word(input logic [WORD_BITS-1:0] addr);
        if (store.exists(addr)) begin
            return store[addr];
        end
        return addr ^ 32'h5a5a_5a5a;    // fill pattern
    endfunction

    initial begin
        lfsr      = 32'h7de1;
        mem_busy  = 1'b1;
        mem_rdata = '0;
        wr_count  = 0;
    end

    always @(mem_addr, wr_count) begin
        mem_rdata = read_word(mem_addr);
    end

    //////////////////////////////////////////////////
    // writes at the edge, new stall 2 ns later
    //////////////////////////////////////////////////
    always @(posedge CLK) begin
        if (mem_wen && !mem_busy) begin
            store[mem_addr] = mem_wdata;
            wr_count        = wr_count + 1;
        end
        #2;
        lfsr     = lfsr_step(lfsr);
        stall_a  = lfsr[0];
        lfsr     = lfsr_step(lfsr);
        stall_b  = lfsr[0];
        mem_busy = stall_a & stall_b;    // roughly one cycle in four
    end

endmodule

// File: bench/l2_cache_tb.sv
`timescale 1ns/1ps

module l2_cache_tb import l2_geom_pkg::*, l2_ctrl_pkg::*; ();

    localparam logic [WORD_BITS-1:0] EMPTY_SLOT  = '1;    // above NONCACHE_BASE, never cached
    localparam int unsigned          BLOCK_BYTES = BLOCK_WORDS * WORD_STEP;
    localparam int                   WAIT_LIMIT  = 400;   // negedges per access

    logic                 CLK;
    logic                 nRST;
    logic [WORD_BITS-1:0] proc_addr;
    logic                 proc_ren;
    logic                 proc_wen;
    logic [WORD_BITS-1:0] proc_wdata;
    logic [WORD_BITS-1:0] proc_rdata;
    logic                 proc_busy;
    logic [WORD_BITS-1:0] mem_addr;
    logic                 mem_ren;
    logic                 mem_wen;
    logic [WORD_BITS-1:0] mem_wdata;
    logic [WORD_BITS-1:0] mem_rdata;
    logic                 mem_busy;

    logic [WORD_BITS-1:0] exp_rdata;
    logic                 expect_hit;
    logic [WORD_BITS-1:0] shadow    [logic [WORD_BITS-1:0]];
    bit                   dirty_blk [logic [WORD_BITS-1:0]];
    logic [WORD_BITS-1:0] resident  [N_SETS][$];    // block addresses, oldest first
    logic [2*WORD_BITS:0] exp_q [$];                // {wen, addr, data}
    logic [2*WORD_BITS:0] log_q [$];

    l2_cache l2_cache_inst (.*);
    l2_mem_model mem_model_inst (.*);

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    //////////////////////////////////////////////////
    // error reporting and checks
    //////////////////////////////////////////////////
    task automatic stop_with_failure();
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [WORD_BITS-1:0] got,
                                   input logic [WORD_BITS-1:0] want);
        $display("** Error: %s is %h, expected %h", name, got, want);
        stop_with_failure();
    endtask

    assert property (@(posedge CLK) disable iff (!nRST)
                     (proc_ren && !proc_busy) |-> (proc_rdata == exp_rdata))
        else report_mismatch("proc_rdata", $sampled(proc_rdata), $sampled(exp_rdata));

    assert property (@(posedge CLK) disable iff (!nRST)
                     (expect_hit && (proc_ren || proc_wen)) |->
                     (!proc_busy && !mem_ren && !mem_wen))
        else begin
            $display("hit at %h stalled or reached the memory bus", $sampled(proc_addr));
            stop_with_failure();
        end

    assert property (@(posedge CLK) disable iff (!nRST) !(mem_ren && mem_wen))
        else begin
            $display("mem_ren and mem_wen were high in the same cycle");
            stop_with_failure();
        end

    // bus values are stable from 2 ns after the edge, so grab them at the falling edge
    always @(negedge CLK) begin
        if (nRST && (mem_ren || mem_wen) && !mem_busy) begin
            log_q.push_back({mem_wen, mem_addr, mem_wen ? mem_wdata : mem_rdata});
        end
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////
    function automatic logic [WORD_BITS-1:0] shadow_value(input logic [WORD_BITS-1:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return addr ^ 32'h5a5a_5a5a;
    endfunction

    function automatic void expect_burst(input bit wen, input logic [WORD_BITS-1:0] base);
        logic [WORD_BITS-1:0] a;
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            a = base + WORD_BITS'(i * WORD_STEP);    // increasing word order
            exp_q.push_back({wen, a, shadow_value(a)});
        end
    endfunction

    function automatic void update_model(input bit wr, input logic [WORD_BITS-1:0] addr,
                                         output bit was_hit);
        logic [WORD_BITS-1:0] blk;
        logic [WORD_BITS-1:0] victim;
        logic [SET_BITS-1:0]  set;
        int                   pos;
        blk = addr & ~WORD_BITS'(BLOCK_BYTES - 1);
        set = addr[BYTE_OFS_BITS + WORD_SEL_BITS +: SET_BITS];
        pos = -1;
        for (int i = 0; i < resident[set].size(); i++) begin
            if (resident[set][i] == blk) begin
                pos = i;
            end
        end
        was_hit = (pos >= 0);
        if (was_hit) begin
            resident[set].delete(pos);
        end else begin
            victim = resident[set].pop_front();    // oldest goes
            if (victim != EMPTY_SLOT && dirty_blk.exists(victim)) begin
                expect_burst(1'b1, victim);
                dirty_blk.delete(victim);
            end
            expect_burst(1'b0, blk);
        end
        resident[set].push_back(blk);
        if (wr) begin
            dirty_blk[blk] = 1'b1;
        end
    endfunction

    task automatic check_traffic();
        logic [2*WORD_BITS:0] got;
        logic [2*WORD_BITS:0] want;
        assert (log_q.size() == exp_q.size())
            else report_mismatch("memory transfer count", log_q.size(), exp_q.size());
        for (int i = 0; i < exp_q.size(); i++) begin
            got  = log_q[i];
            want = exp_q[i];
            assert (got[2*WORD_BITS] == want[2*WORD_BITS])
                else report_mismatch("mem_wen", got[2*WORD_BITS], want[2*WORD_BITS]);
            assert (got[2*WORD_BITS-1 -: WORD_BITS] == want[2*WORD_BITS-1 -: WORD_BITS])
                else report_mismatch("mem_addr", got[2*WORD_BITS-1 -: WORD_BITS],
                                     want[2*WORD_BITS-1 -: WORD_BITS]);
            assert (got[WORD_BITS-1:0] == want[WORD_BITS-1:0])
                else report_mismatch(want[2*WORD_BITS] ? "mem_wdata" : "mem_rdata",
                                     got[WORD_BITS-1:0], want[WORD_BITS-1:0]);
        end
        log_q.delete();
        exp_q.delete();
    endtask

    // called 2 ns after a rising edge, returns at the same point of a later cycle
    task automatic access(input bit wr, input logic [WORD_BITS-1:0] addr,
                          input logic [WORD_BITS-1:0] wdata);
        bit was_hit;
        int waited;
        was_hit = 1'b0;
        if (addr >= NONCACHE_BASE) begin
            exp_q.push_back({wr, addr, wr ? wdata : shadow_value(addr)});
        end else begin
            update_model(wr, addr, was_hit);
        end
        exp_rdata  = shadow_value(addr);
        expect_hit = was_hit;
        proc_addr  = addr;
        proc_wdata = wdata;
        proc_ren   = !wr;
        proc_wen   = wr;
        waited     = 0;
        @(negedge CLK);
        while (proc_busy) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("timeout, access to %h never completed", addr);
                stop_with_failure();
            end
            @(negedge CLK);
        end
        @(posedge CLK);
        #2;
        proc_ren   = 1'b0;
        proc_wen   = 1'b0;
        expect_hit = 1'b0;
        if (wr) begin
            shadow[addr] = wdata;
        end
        check_traffic();
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    initial begin
        nRST       = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        proc_ren   = 1'b0;
        proc_wen   = 1'b0;
        exp_rdata  = '0;
        expect_hit = 1'b0;
        for (int s = 0; s < N_SETS; s++) begin
            for (int i = 0; i < WAYS; i++) begin
                resident[s].push_back(EMPTY_SLOT);
            end
        end
        repeat (4) @(posedge CLK);
        #2;
        nRST = 1'b1;

        access(1'b0, 32'h0000_0104, '0);            // read miss, refill
        access(1'b0, 32'h0000_0108, '0);
        access(1'b1, 32'h0000_010c, 32'hc0de_0001);  // write hit
        access(1'b0, 32'h0000_010c, '0);

        // five tags in set 0 with touches in between
        access(1'b0, 32'h0000_0080, '0);
        access(1'b0, 32'h0000_0184, '0);
        access(1'b0, 32'h0000_0200, '0);
        access(1'b0, 32'h0000_0100, '0);            // 0x080 now oldest
        access(1'b0, 32'h0000_0288, '0);
        access(1'b1, 32'h0000_0184, 32'hbeef_0002);
        access(1'b0, 32'h0000_0204, '0);
        access(1'b0, 32'h0000_0108, '0);
        access(1'b0, 32'h0000_0280, '0);
        access(1'b0, 32'h0000_0300, '0);            // dirty 0x180 written back
        access(1'b0, 32'h0000_0080, '0);
        access(1'b0, 32'h0000_0380, '0);            // dirty 0x100 goes next

        // uncached window
        access(1'b1, 32'h8000_0010, 32'h1234_5678);
        access(1'b0, 32'h8000_0010, '0);
        access(1'b0, 32'h8000_0010, '0);
        access(1'b0, 32'h8000_0024, '0);

        // mixed sweep over all sets
        for (int i = 0; i < 48; i++) begin
            access((i % 3) == 0, (i * 32'h0000_0094) & 32'h0000_07fc, 32'h1111_0000 + i);
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: tb.f
rtl/l2_geom_pkg.sv
rtl/l2_ctrl_pkg.sv
rtl/l2_frame_store.sv
rtl/l2_lru.sv
rtl/l2_controller.sv
rtl/l2_cache.sv
bench/l2_mem_model.sv
bench/l2_cache_tb.sv
